//--- lawnDefense_params.svh
`ifndef LAWN_DEFENSE_PARAMS_SVH
`define LAWN_DEFENSE_PARAMS_SVH

// Lane and grid counts
`define ZOMBIE_LANES 5
`define GRID_COLS 5
// A zombie survives this many hits minus one
`define HITS_TO_KILL 5

// Lawn geometry in pixels
`define LAWN_LEFT 300
// Everything above the lawn is the grey plant strip
`define LAWN_TOP 87
`define COLUMN_WIDTH 100
`define ROW_HEIGHT 87
`define PLANT_BOX_WIDTH 80
`define PLANT_INSET 20
`define OUTLINE_WIDTH 2

// Zombie geometry
`define ZOMBIE_START_X 799
`define END_OF_LAWN 124
`define ZOMBIE_BODY_HEIGHT 50
`define HALF_ZOMBIE_BODY_WIDTH 8

// Staggered entry thresholds on the leader's X position
`define RELEASE_NEAR 600
`define RELEASE_FAR 700

// Clocks per one-pixel step at a 100 MHz pixel clock
`define DEFAULT_STEP_CYCLES 1000000

// Colours as 4 bits each of red, green and blue
`define BLACK 12'h000
`define GREEN 12'h0F0
`define DARK_GREEN 12'h392
`define GREY 12'hAAB
`define RED 12'hF00
`define ZOMBIE_SKIN 12'h0B4
`define PEASHOOTER_COLOR 12'h2C2
`define SUNFLOWER_COLOR 12'hFF0
`define WALNUT_COLOR 12'h963

`endif

//--- lawnPkg.sv
`include "lawnDefense_params.svh"

package lawnPkg;

	// Screen coordinate, wide enough for an 800 by 525 frame
	typedef logic [9:0] coordT;

	// Pixel colour in 4:4:4 format
	typedef logic [11:0] rgbT;

	// What occupies a lawn cell
	typedef enum logic [1:0]
	{
		none,
		peashooter,
		sunflower,
		walnut
	} plantKindT;

	// won and lost are held until reset
	typedef enum logic [1:0]
	{
		playing,
		won,
		lost
	} gameStateT;

	// The cursor either walks the box strip or the lawn grid
	typedef enum logic
	{
		pickPlant,
		pickCell
	} cursorModeT;

	// Lane i's zombie sits at x[i] and is drawn only while alive[i] is set
	typedef struct packed
	{
		coordT [`ZOMBIE_LANES-1:0] x;
		logic [`ZOMBIE_LANES-1:0] alive;
	} zombieFieldT;

	// One plant per cell, indexed row times GRID_COLS plus column
	typedef plantKindT [`ZOMBIE_LANES*`GRID_COLS-1:0] plantFieldT;

	typedef struct packed
	{
		cursorModeT mode;
		logic [1:0] box;
		logic [2:0] row;
		logic [2:0] col;
		plantKindT kind;
	} cursorT;

	// Each field is a one-cycle pulse
	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
		logic select;
	} buttonsT;

	typedef struct packed
	{
		logic [2:0] lane;
	} peaHitT;

endpackage

//--- zombieLanes.sv
`timescale 1ns/1ps
`include "lawnDefense_params.svh"

module zombieLanes #(
	parameter int stepCycles = `DEFAULT_STEP_CYCLES
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  lawnPkg::peaHitT      peaHit,
	input  logic                 peaHitValid,
	output logic                 peaHitReady,
	output lawnPkg::zombieFieldT zombies,
	output logic [3:0]           zombiesKilled,
	output lawnPkg::gameStateT   gameState
);
	import lawnPkg::*;

	logic [31:0] stepCnt;
	logic stepTick;
	logic hitFire;
	// Lanes allowed to walk on a step
	logic [`ZOMBIE_LANES-1:0] released;
	// Live zombies sitting on the losing column
	logic [`ZOMBIE_LANES-1:0] atEnd;
	logic [2:0] hitCnt [`ZOMBIE_LANES];

	// Hits are only taken while the game is running
	assign peaHitReady = (gameState == playing);
	assign hitFire = peaHitValid && peaHitReady;
	assign stepTick = (stepCnt == 32'(stepCycles - 1));

	// Free-running pacing counter, one tick every stepCycles clocks
	always_ff @(posedge clk)
	begin
		if (!rstN)
			stepCnt <= '0;
		else if (stepTick)
			stepCnt <= '0;
		else
			stepCnt <= stepCnt + 32'd1;
	end

	// Lane 1 leads and the others follow in a fixed stagger
	always_comb
	begin
		released[1] = 1'b1;
		released[0] = (zombies.x[1] <= `RELEASE_NEAR);
		released[2] = (zombies.x[0] <= `RELEASE_NEAR);
		released[3] = (zombies.x[0] <= `RELEASE_FAR);
		released[4] = (zombies.x[3] <= `RELEASE_FAR);
		for (int i = 0; i < `ZOMBIE_LANES; i++)
			atEnd[i] = zombies.alive[i] && (zombies.x[i] == 10'(`END_OF_LAWN));
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `ZOMBIE_LANES; i++)
			begin
				zombies.x[i] <= 10'(`ZOMBIE_START_X);
				hitCnt[i] <= '0;
			end
			zombies.alive <= '1;
			zombiesKilled <= '0;
			gameState <= playing;
		end
		else
		begin
			// A step either ends the game or walks every released live zombie
			if (gameState == playing && stepTick)
			begin
				if (|atEnd)
					gameState <= lost;
				else
					for (int i = 0; i < `ZOMBIE_LANES; i++)
						if (released[i] && zombies.alive[i])
							zombies.x[i] <= zombies.x[i] - 10'd1;
			end
			// Hits on a dead lane are accepted and dropped
			if (hitFire)
			begin
				for (int i = 0; i < `ZOMBIE_LANES; i++)
				begin
					if (peaHit.lane == 3'(i) && zombies.alive[i])
					begin
						hitCnt[i] <= hitCnt[i] + 3'd1;
						if (hitCnt[i] == 3'(`HITS_TO_KILL - 1))
						begin
							zombies.alive[i] <= 1'b0;
							zombiesKilled <= zombiesKilled + 4'd1;
						end
					end
				end
			end
			// The win lands one edge after the last kill
			if (gameState == playing && zombiesKilled == 4'(`ZOMBIE_LANES))
				gameState <= won;
		end
	end

	// A source must never name a lane beyond the lawn
	laneInRange: assert property (@(posedge clk) disable iff (!rstN)
		peaHitValid |-> (peaHit.lane < `ZOMBIE_LANES));

	// Each lane can be killed once, so the tally is bounded by the lane count
	killBound: assert property (@(posedge clk) disable iff (!rstN)
		zombiesKilled <= `ZOMBIE_LANES);

endmodule

//--- plantGrid.sv
`timescale 1ns/1ps
`include "lawnDefense_params.svh"

module plantGrid (
	input  logic                clk,
	input  logic                rstN,
	input  lawnPkg::buttonsT    buttons,
	output lawnPkg::cursorT     cursor,
	output lawnPkg::plantFieldT plants
);
	import lawnPkg::*;

	// Three selection boxes in the grey strip
	localparam int lastBox = 2;
	localparam int lastRow = `ZOMBIE_LANES - 1;
	localparam int lastCol = `GRID_COLS - 1;

	logic [4:0] cellIdx;
	plantKindT boxKind;

	// Flat index of the cell under the cursor
	assign cellIdx = 5'(cursor.row) * 5'(`GRID_COLS) + 5'(cursor.col);

	// Box order in the strip is peashooter, sunflower, walnut
	always_comb
	begin
		case (cursor.box)
			2'd0: boxKind = peashooter;
			2'd1: boxKind = sunflower;
			default: boxKind = walnut;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			cursor.mode <= pickPlant;
			cursor.box <= '0;
			cursor.row <= '0;
			cursor.col <= '0;
			cursor.kind <= none;
			for (int i = 0; i < `ZOMBIE_LANES * `GRID_COLS; i++)
				plants[i] <= none;
		end
		else if (cursor.mode == pickPlant)
		begin
			// Choosing a box moves the cursor onto the top left cell
			if (buttons.select)
			begin
				cursor.kind <= boxKind;
				cursor.mode <= pickCell;
				cursor.row <= '0;
				cursor.col <= '0;
			end
			else if (buttons.left && cursor.box != 2'd0)
				cursor.box <= cursor.box - 2'd1;
			else if (buttons.right && cursor.box != 2'(lastBox))
				cursor.box <= cursor.box + 2'd1;
		end
		else
		begin
			if (buttons.select)
			begin
				// An occupied cell keeps its plant
				if (plants[cellIdx] == none)
					plants[cellIdx] <= cursor.kind;
				cursor.mode <= pickPlant;
				cursor.box <= '0;
			end
			// Moves stop at the lawn edges
			else if (buttons.up && cursor.row != 3'd0)
				cursor.row <= cursor.row - 3'd1;
			else if (buttons.down && cursor.row != 3'(lastRow))
				cursor.row <= cursor.row + 3'd1;
			else if (buttons.left && cursor.col != 3'd0)
				cursor.col <= cursor.col - 3'd1;
			else if (buttons.right && cursor.col != 3'(lastCol))
				cursor.col <= cursor.col + 3'd1;
		end
	end

	// The clamping must keep the cursor on the 5 by 5 lawn
	cursorOnLawn: assert property (@(posedge clk) disable iff (!rstN)
		(cursor.row < `ZOMBIE_LANES) && (cursor.col < `GRID_COLS));

endmodule

//--- pixelComposer.sv
`timescale 1ns/1ps
`include "lawnDefense_params.svh"

module pixelComposer (
	input  logic                 clk,
	input  logic                 rstN,
	input  lawnPkg::coordT       hCount,
	input  lawnPkg::coordT       vCount,
	input  logic                 bright,
	input  lawnPkg::zombieFieldT zombies,
	input  lawnPkg::plantFieldT  plants,
	input  lawnPkg::cursorT      cursor,
	output lawnPkg::rgbT         rgb
);
	import lawnPkg::*;

	localparam int lawnRight = `LAWN_LEFT + `GRID_COLS * `COLUMN_WIDTH;
	localparam int lawnBottom = `LAWN_TOP + `ZOMBIE_LANES * `ROW_HEIGHT;

	logic [2:0] pixRow;
	logic [2:0] pixCol;
	logic [4:0] pixIdx;
	logic inLawn;
	coordT cellLeft, cellTop;
	coordT offX, offY;
	coordT boxLeft, boxOffX;
	plantKindT pixPlant;
	logic onCellOutline, onBoxOutline, onZombie, onPlant, oddCell;
	rgbT plantRgb;
	rgbT nextRgb;

	// Find the lawn cell under the pixel by threshold compares
	always_comb
	begin
		pixRow = '0;
		pixCol = '0;
		for (int r = 1; r < `ZOMBIE_LANES; r++)
			if (vCount >= `LAWN_TOP + r * `ROW_HEIGHT)
				pixRow = 3'(r);
		for (int c = 1; c < `GRID_COLS; c++)
			if (hCount >= `LAWN_LEFT + c * `COLUMN_WIDTH)
				pixCol = 3'(c);
	end

	assign inLawn = (hCount >= `LAWN_LEFT) && (hCount < lawnRight)
		&& (vCount >= `LAWN_TOP) && (vCount < lawnBottom);
	assign cellLeft = 10'(`LAWN_LEFT + pixCol * `COLUMN_WIDTH);
	assign cellTop = 10'(`LAWN_TOP + pixRow * `ROW_HEIGHT);
	// Position inside the cell, only meaningful on the lawn
	assign offX = hCount - cellLeft;
	assign offY = vCount - cellTop;
	assign pixIdx = 5'(pixRow) * 5'(`GRID_COLS) + 5'(pixCol);
	assign pixPlant = plants[pixIdx];
	assign oddCell = pixRow[0] ^ pixCol[0];

	// Red frame around the cursor's lawn cell
	assign onCellOutline = (cursor.mode == pickCell) && inLawn
		&& (pixRow == cursor.row) && (pixCol == cursor.col)
		&& ((offX < `OUTLINE_WIDTH) || (offX >= `COLUMN_WIDTH - `OUTLINE_WIDTH)
		|| (offY < `OUTLINE_WIDTH) || (offY >= `ROW_HEIGHT - `OUTLINE_WIDTH));

	// Red frame around the chosen box in the grey strip
	assign boxLeft = 10'(cursor.box * `PLANT_BOX_WIDTH);
	assign boxOffX = hCount - boxLeft;
	assign onBoxOutline = (cursor.mode == pickPlant) && (vCount < `LAWN_TOP)
		&& (hCount >= boxLeft) && (hCount < boxLeft + `PLANT_BOX_WIDTH)
		&& ((boxOffX < `OUTLINE_WIDTH) || (boxOffX >= `PLANT_BOX_WIDTH - `OUTLINE_WIDTH)
		|| (vCount < `OUTLINE_WIDTH) || (vCount >= `LAWN_TOP - `OUTLINE_WIDTH));

	// Body rectangle hangs from the top of its lane
	always_comb
	begin
		int laneTop;
		onZombie = 1'b0;
		for (int i = 0; i < `ZOMBIE_LANES; i++)
		begin
			laneTop = `LAWN_TOP + i * `ROW_HEIGHT;
			if (zombies.alive[i] && (vCount >= laneTop)
				&& (vCount < laneTop + `ZOMBIE_BODY_HEIGHT)
				&& (hCount + `HALF_ZOMBIE_BODY_WIDTH >= zombies.x[i])
				&& (hCount <= zombies.x[i] + `HALF_ZOMBIE_BODY_WIDTH))
				onZombie = 1'b1;
		end
	end

	// Plants are squares inset from the cell edges
	assign onPlant = inLawn && (pixPlant != none)
		&& (offX >= `PLANT_INSET) && (offX < `COLUMN_WIDTH - `PLANT_INSET)
		&& (offY >= `PLANT_INSET) && (offY < `ROW_HEIGHT - `PLANT_INSET);

	always_comb
	begin
		case (pixPlant)
			peashooter: plantRgb = `PEASHOOTER_COLOR;
			sunflower: plantRgb = `SUNFLOWER_COLOR;
			default: plantRgb = `WALNUT_COLOR;
		endcase
	end

	// Highest priority layer wins
	always_comb
	begin
		if (!bright)
			nextRgb = `BLACK;
		else if (onCellOutline || onBoxOutline)
			nextRgb = `RED;
		else if (onZombie)
			nextRgb = `ZOMBIE_SKIN;
		else if (onPlant)
			nextRgb = plantRgb;
		else if (vCount < `LAWN_TOP)
			nextRgb = `GREY;
		else if (inLawn && oddCell)
			nextRgb = `DARK_GREEN;
		else
			nextRgb = `GREEN;
	end

	// One cycle from pixel coordinates to colour
	always_ff @(posedge clk)
	begin
		if (!rstN)
			rgb <= `BLACK;
		else
			rgb <= nextRgb;
	end

endmodule

//--- lawnDefense.sv
`timescale 1ns/1ps
`include "lawnDefense_params.svh"

module lawnDefense #(
	parameter int stepCycles = `DEFAULT_STEP_CYCLES
) (
	input  logic               clk,
	input  logic               rstN,
	input  lawnPkg::buttonsT   buttons,
	input  lawnPkg::peaHitT    peaHit,
	input  logic               peaHitValid,
	output logic               peaHitReady,
	input  lawnPkg::coordT     hCount,
	input  lawnPkg::coordT     vCount,
	input  logic               bright,
	output lawnPkg::rgbT       rgb,
	output logic [3:0]         zombiesKilled,
	output lawnPkg::gameStateT gameState
);
	import lawnPkg::*;

	// Game state handed to the renderer
	zombieFieldT zombies;
	plantFieldT plants;
	cursorT cursor;

	// Zombie movement, hits and the win or loss decision
	zombieLanes #(
		.stepCycles(stepCycles)
	) u_zombieLanes (
		.clk(clk),
		.rstN(rstN),
		.peaHit(peaHit),
		.peaHitValid(peaHitValid),
		.peaHitReady(peaHitReady),
		.zombies(zombies),
		.zombiesKilled(zombiesKilled),
		.gameState(gameState)
	);

	// Player cursor and the placed plants
	plantGrid u_plantGrid (
		.clk(clk),
		.rstN(rstN),
		.buttons(buttons),
		.cursor(cursor),
		.plants(plants)
	);

	pixelComposer u_pixelComposer (
		.clk(clk),
		.rstN(rstN),
		.hCount(hCount),
		.vCount(vCount),
		.bright(bright),
		.zombies(zombies),
		.plants(plants),
		.cursor(cursor),
		.rgb(rgb)
	);

endmodule

//--- lawnDefenseTb.sv
`timescale 1ns/1ps
`include "lawnDefense_params.svh"

module lawnDefenseTb;
	import lawnPkg::*;

	localparam int stepCycles = 2;
	localparam int clkPeriod = 40;
	// The loss test walks 675 steps of 2 clocks and the rest is headroom for the short tests
	localparam int watchdogCycles = 4000;
	// The lead zombie needs one step per pixel plus the step that sees the end
	localparam int lossBound = (`ZOMBIE_START_X - `END_OF_LAWN + 2) * stepCycles + 10;
	localparam int readyTimeout = 20;

	typedef enum {btnUp, btnDown, btnLeft, btnRight, btnSelect} buttonNameT;

	logic clk;
	logic rstN;
	buttonsT buttons;
	peaHitT peaHit;
	logic peaHitValid;
	logic peaHitReady;
	coordT hCount;
	coordT vCount;
	logic bright;
	rgbT rgb;
	logic [3:0] zombiesKilled;
	gameStateT gameState;

	int errors;
	int seed;
	// Reference count of accepted hits per lane and of dead zombies
	int hitsModel [`ZOMBIE_LANES];
	int killedModel;

	lawnDefense #(
		.stepCycles(stepCycles)
	) u_lawnDefense (
		.clk(clk),
		.rstN(rstN),
		.buttons(buttons),
		.peaHit(peaHit),
		.peaHitValid(peaHitValid),
		.peaHitReady(peaHitReady),
		.hCount(hCount),
		.vCount(vCount),
		.bright(bright),
		.rgb(rgb),
		.zombiesKilled(zombiesKilled),
		.gameState(gameState)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		repeat (watchdogCycles)
			@(posedge clk);
		$display("Watchdog expired after %0d cycles before the tests finished", watchdogCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// Pixel positions worked out from the lawn geometry
	function automatic int centreX(input int col);
		return `LAWN_LEFT + col * `COLUMN_WIDTH + `COLUMN_WIDTH / 2;
	endfunction

	function automatic int centreY(input int row);
		return `LAWN_TOP + row * `ROW_HEIGHT + `ROW_HEIGHT / 2;
	endfunction

	function automatic int cellLeft(input int col);
		return `LAWN_LEFT + col * `COLUMN_WIDTH;
	endfunction

	// Inputs change 2 ns after the edge so the DUT never sees them move at the edge
	task automatic afterEdge();
		@(posedge clk);
		#2;
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		repeat (8)
			afterEdge();
		rstN = 1'b1;
		for (int i = 0; i < `ZOMBIE_LANES; i++)
			hitsModel[i] = 0;
		killedModel = 0;
	endtask

	// The colour for a pixel shows one edge after it is applied
	task automatic expectColour(input int x, input int y, input logic br, input rgbT expected,
		input string what);
		hCount = coordT'(x);
		vCount = coordT'(y);
		bright = br;
		afterEdge();
		if (rgb !== expected)
		begin
			errors++;
			$display("ERROR %0t: %s at (%0d,%0d) is %h, expected %h", $time, what, x, y, rgb,
				expected);
		end
	endtask

	task automatic expectKills(input int expected, input string what);
		if (zombiesKilled !== 4'(expected))
		begin
			errors++;
			$display("ERROR %0t: zombiesKilled %s is %0d, expected %0d", $time, what,
				zombiesKilled, expected);
		end
	endtask

	task automatic expectState(input int killed, input gameStateT state, input logic ready,
		input string what);
		expectKills(killed, what);
		if (gameState !== state)
		begin
			errors++;
			$display("ERROR %0t: gameState %s is %0d, expected %0d", $time, what, gameState, state);
		end
		if (peaHitReady !== ready)
		begin
			errors++;
			$display("ERROR %0t: peaHitReady %s is %b, expected %b", $time, what, peaHitReady,
				ready);
		end
	endtask

	// Each press is a one-cycle pulse followed by an idle cycle
	task automatic pressButton(input buttonNameT which, input int times);
		buttonsT pulse;
		pulse = '0;
		case (which)
			btnUp: pulse.up = 1'b1;
			btnDown: pulse.down = 1'b1;
			btnLeft: pulse.left = 1'b1;
			btnRight: pulse.right = 1'b1;
			default: pulse.select = 1'b1;
		endcase
		repeat (times)
		begin
			buttons = pulse;
			afterEdge();
			buttons = '0;
			afterEdge();
		end
	endtask

	// Holds the hit until ready is seen ahead of an edge, then updates the lane model
	task automatic sendHit(input int lane);
		int waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		peaHit.lane = 3'(lane);
		peaHitValid = 1'b1;
		while (!taken && waited < readyTimeout)
		begin
			// Ready only moves on an edge, so this value holds at the coming edge
			taken = peaHitReady;
			afterEdge();
			waited++;
		end
		peaHitValid = 1'b0;
		if (!taken)
		begin
			errors++;
			$display("Hit on lane %0d was never accepted because peaHitReady stayed low", lane);
		end
		else if (hitsModel[lane] < `HITS_TO_KILL)
		begin
			hitsModel[lane]++;
			if (hitsModel[lane] == `HITS_TO_KILL)
				killedModel++;
		end
	endtask

	task automatic testBackground();
		expectColour(100, 40, 1'b0, `BLACK, "blanked pixel");
		expectColour(100, 40, 1'b1, `GREY, "grey strip");
		expectColour(100, 200, 1'b1, `GREEN, "left of the lawn");
		expectColour(centreX(1), centreY(0), 1'b1, `DARK_GREEN, "centre of cell (0,1)");
		expectColour(centreX(0), centreY(0), 1'b1, `GREEN, "centre of cell (0,0)");
		// Lane 0 waits at the start until lane 1 has walked to the near threshold
		expectColour(`ZOMBIE_START_X, `LAWN_TOP + 10, 1'b1, `ZOMBIE_SKIN,
			"waiting zombie in lane 0");
		expectState(0, playing, 1'b1, "after reset");
	endtask

	task automatic testPlacement();
		// Box 1 is the sunflower and choosing it puts the cursor on cell (0,0)
		pressButton(btnRight, 1);
		pressButton(btnSelect, 1);
		expectColour(cellLeft(0), centreY(0), 1'b1, `RED, "cursor border of cell (0,0)");
		pressButton(btnRight, 3);
		pressButton(btnDown, 1);
		pressButton(btnSelect, 1);
		expectColour(centreX(3), centreY(1), 1'b1, `SUNFLOWER_COLOR, "sunflower in cell (1,3)");
		// The strip is back at box 0, so this pick is a peashooter
		pressButton(btnSelect, 1);
		pressButton(btnRight, 2);
		pressButton(btnLeft, 5);
		expectColour(cellLeft(0), centreY(0), 1'b1, `RED, "clamped cursor on column 0");
		expectColour(cellLeft(1), centreY(0), 1'b1, `DARK_GREEN, "left edge of cell (0,1)");
		pressButton(btnSelect, 1);
		expectColour(centreX(0), centreY(0), 1'b1, `PEASHOOTER_COLOR, "peashooter in cell (0,0)");
	endtask

	task automatic testOccupiedCell();
		pressButton(btnRight, 2);
		pressButton(btnSelect, 1);
		pressButton(btnRight, 3);
		pressButton(btnDown, 1);
		pressButton(btnSelect, 1);
		expectColour(centreX(3), centreY(1), 1'b1, `SUNFLOWER_COLOR, "occupied cell (1,3)");
	endtask

	task automatic testHitCounting();
		int lane;
		repeat (4)
			sendHit(2);
		expectKills(0, "after four hits on lane 2");
		sendHit(2);
		expectKills(1, "after the fifth hit on lane 2");
		repeat (2)
			sendHit(2);
		expectKills(1, "after hits on dead lane 2");
		// Eight hits cannot finish the four remaining lanes, so the game keeps running
		repeat (8)
		begin
			lane = $unsigned($random(seed)) % `ZOMBIE_LANES;
			sendHit(lane);
			expectKills(killedModel, "during the random hits");
		end
	endtask

	task automatic testWin();
		int waited;
		for (int lane = 0; lane < `ZOMBIE_LANES; lane++)
			while (hitsModel[lane] < `HITS_TO_KILL)
				sendHit(lane);
		expectKills(`ZOMBIE_LANES, "after every lane is killed");
		waited = 0;
		while (gameState != won && waited < 2)
		begin
			afterEdge();
			waited++;
		end
		expectState(`ZOMBIE_LANES, won, 1'b0, "after the last kill");
		// A dead zombie leaves the lawn under it visible
		expectColour(`ZOMBIE_START_X, `LAWN_TOP + 10, 1'b1, `GREEN, "killed zombie in lane 0");
	endtask

	task automatic testLoss();
		int waited;
		applyReset();
		expectState(0, playing, 1'b1, "after the second reset");
		waited = 0;
		while (gameState != lost && waited < lossBound)
		begin
			afterEdge();
			waited++;
		end
		if (gameState != lost)
		begin
			errors++;
			$display("Game did not reach the lost state within %0d cycles", lossBound);
		end
		else
		begin
			expectState(0, lost, 1'b0, "after the loss");
			// Lane 1 leads and stays on the losing column once the game is over
			expectColour(`END_OF_LAWN, `LAWN_TOP + `ROW_HEIGHT + 10, 1'b1, `ZOMBIE_SKIN,
				"zombie at the end of the lawn");
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		buttons = '0;
		peaHit = '0;
		peaHitValid = 1'b0;
		hCount = '0;
		vCount = '0;
		bright = 1'b0;
		errors = 0;
		seed = 32'hdb44;
		applyReset();
		testBackground();
		testPlacement();
		testOccupiedCell();
		testHitCounting();
		testWin();
		testLoss();
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- lawnDefense.f
+incdir+.
lawnPkg.sv
zombieLanes.sv
plantGrid.sv
pixelComposer.sv
lawnDefense.sv
lawnDefenseTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and pass only if the pass line appears
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f lawnDefense.f \
		--top-module lawnDefenseTb \
	&& ./obj_dir/VlawnDefenseTb | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
